/* design/regmap_pkg.sv */
package regmap_pkg;

	// local bus widths
	localparam int lb_aw = 24;
	localparam int lb_dw = 32;

	typedef logic [lb_aw-1:0] lb_addr_t;  // word address
	typedef logic [lb_dw-1:0] lb_data_t;

	// register map, word addresses
	localparam lb_addr_t addr_periph_config  = 24'd0;     // [0] pwr_en, [1] adc_pdwn
	localparam lb_addr_t addr_bitslip        = 24'd1;     // [7:0] U2, [15:8] U3
	localparam lb_addr_t addr_clk_status     = 24'd2;
	localparam lb_addr_t addr_capture_trig   = 24'd3;     // any write starts capture
	localparam lb_addr_t addr_banyan_mask    = 24'd4;
	localparam lb_addr_t addr_sync_cset      = 24'd5;     // [9:0] ad7794, [21:16] tps62210
	localparam lb_addr_t addr_capture_status = 24'd16;
	localparam lb_addr_t addr_freq_a         = 24'd17;
	localparam lb_addr_t addr_freq_b         = 24'd18;
	localparam lb_addr_t idelay_base         = 24'd112;   // 16 taps
	localparam lb_addr_t capture_base        = 24'd2048;  // 8 ch x 256 samples
	localparam int idelay_aw      = 4;   // idelay window is 2**idelay_aw words
	localparam int capture_win_aw = 11;  // capture window is 2**capture_win_aw words

	// sync generator settings
	localparam int cset_ad7794_w    = 10;
	localparam int cset_tps62210_w  = 6;
	localparam int sync_ad7794_minc   = 256;
	localparam int sync_tps62210_minc = 32;

	// frequency counter gate, 4096 lb_clk cycles
	localparam int freq_gate_log2 = 12;
	typedef logic [27:0] freq_t;

	// tracks whether the MMCM stayed locked since set-up
	typedef enum logic [1:0] {
		clk_reset    = 2'd0,
		clk_set_up   = 2'd1,
		clk_verified = 2'd2
	} clk_status_t;

	typedef struct packed {
		logic       pwr_en;
		logic       adc_pdwn;
		logic [7:0] bitslip_u2;
		logic [7:0] bitslip_u3;
	} periph_cfg_t;

	typedef struct packed {
		logic                 strobe;  // single cycle
		logic [idelay_aw-1:0] addr;    // tap number
		logic [4:0]           value;   // tap delay
	} idelay_cmd_t;

	typedef struct packed {
		logic       trig;  // single cycle
		logic [7:0] mask;  // one bit per ADC channel
	} capture_ctrl_t;

endpackage

/* design/adc_pkg.sv */
package adc_pkg;

	localparam int n_chan  = 8;
	localparam int chan_aw = 3;  // log2 of n_chan
	localparam int sample_w = 16;

	typedef logic [sample_w-1:0] sample_t;
	typedef sample_t [n_chan-1:0] adc_bus_t;  // channel 0 in low bits

	// capture memory depth per channel
	localparam int capture_aw    = 8;
	localparam int capture_depth = 1 << capture_aw;

	typedef logic [capture_aw:0] capture_ptr_t;  // one extra bit to reach depth
	typedef logic [chan_aw+capture_aw-1:0] capture_addr_t;  // {chan, index}

	typedef struct packed {
		logic         run;
		logic         full;
		capture_ptr_t pointer;
	} capture_status_t;

endpackage

/* design/config_regs.sv */
`timescale 1ns/10ps

module config_regs (
	input  logic                              lb_clk,
	input  logic                              reset,
	input  logic                              lb_strobe,
	input  logic                              lb_rd,
	input  regmap_pkg::lb_addr_t              lb_addr,
	input  regmap_pkg::lb_data_t              lb_dout,
	input  logic                              mmcm_locked,
	output regmap_pkg::lb_data_t              lb_din,
	output regmap_pkg::periph_cfg_t           periph_cfg,
	output regmap_pkg::idelay_cmd_t           idelay_cmd,
	output regmap_pkg::capture_ctrl_t         capture_ctrl,
	output logic [regmap_pkg::cset_ad7794_w-1:0]   cset_ad7794,
	output logic [regmap_pkg::cset_tps62210_w-1:0] cset_tps62210,
	output adc_pkg::capture_addr_t            cap_rd_addr,
	input  adc_pkg::sample_t                  cap_rd_data,
	input  adc_pkg::capture_status_t          cap_status,
	input  regmap_pkg::freq_t                 freq_a,
	input  regmap_pkg::freq_t                 freq_b
);

	localparam int iw = regmap_pkg::idelay_aw;
	localparam int cw = regmap_pkg::capture_win_aw;

	logic wr_stb, rd_stb;
	logic in_idelay, in_capture;
	regmap_pkg::clk_status_t clk_state;
	regmap_pkg::lb_data_t    rd_mux;      // register value for this read
	regmap_pkg::lb_data_t    rd_reg_q;    // stage one
	logic                    rd_mem_q;    // stage one, read hits capture window

	assign wr_stb = lb_strobe & ~lb_rd;
	assign rd_stb = lb_strobe & lb_rd;
	assign in_idelay  = lb_addr[regmap_pkg::lb_aw-1:iw] == regmap_pkg::idelay_base[regmap_pkg::lb_aw-1:iw];
	assign in_capture = lb_addr[regmap_pkg::lb_aw-1:cw] == regmap_pkg::capture_base[regmap_pkg::lb_aw-1:cw];

	// capture memory sees the bus address directly, data back one cycle later
	assign cap_rd_addr = lb_addr[cw-1:0];

	// configuration registers and command pulses
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			periph_cfg        <= '0;
			capture_ctrl.mask <= '1;  // all channels on
			capture_ctrl.trig <= 1'b0;
			idelay_cmd        <= '0;
			cset_ad7794       <= '0;
			cset_tps62210     <= '0;
		end else begin
			capture_ctrl.trig <= wr_stb && (lb_addr == regmap_pkg::addr_capture_trig);
			idelay_cmd.strobe <= wr_stb && in_idelay;
			if (wr_stb && in_idelay) begin
				idelay_cmd.addr  <= lb_addr[iw-1:0];
				idelay_cmd.value <= lb_dout[4:0];
			end
			if (wr_stb) begin
				case (lb_addr)
					regmap_pkg::addr_periph_config: begin
						periph_cfg.pwr_en   <= lb_dout[0];
						periph_cfg.adc_pdwn <= lb_dout[1];
					end
					regmap_pkg::addr_bitslip: begin
						periph_cfg.bitslip_u2 <= lb_dout[7:0];
						periph_cfg.bitslip_u3 <= lb_dout[15:8];
					end
					regmap_pkg::addr_banyan_mask: capture_ctrl.mask <= lb_dout[7:0];
					regmap_pkg::addr_sync_cset: begin
						cset_ad7794   <= lb_dout[9:0];
						cset_tps62210 <= lb_dout[21:16];
					end
					default: ;  // commands and read-only words
				endcase
			end
		end
	end

	// clock status FSM, losing lock wins over any write
	always_ff @(posedge lb_clk) begin
		if (reset || !mmcm_locked) begin
			clk_state <= regmap_pkg::clk_reset;
		end else if (wr_stb && (lb_addr == regmap_pkg::addr_clk_status)) begin
			if (lb_dout[1] && (clk_state == regmap_pkg::clk_set_up))
				clk_state <= regmap_pkg::clk_verified;
			else if (lb_dout[0])
				clk_state <= regmap_pkg::clk_set_up;
		end
	end

	// read mux for the register words, zero when unmapped
	always_comb begin
		rd_mux = '0;
		case (lb_addr)
			regmap_pkg::addr_periph_config:
				rd_mux = regmap_pkg::lb_data_t'({periph_cfg.adc_pdwn, periph_cfg.pwr_en});
			regmap_pkg::addr_bitslip:
				rd_mux = regmap_pkg::lb_data_t'({periph_cfg.bitslip_u3, periph_cfg.bitslip_u2});
			regmap_pkg::addr_clk_status:   rd_mux = regmap_pkg::lb_data_t'(clk_state);
			regmap_pkg::addr_banyan_mask:  rd_mux = regmap_pkg::lb_data_t'(capture_ctrl.mask);
			regmap_pkg::addr_sync_cset:
				rd_mux = regmap_pkg::lb_data_t'({cset_tps62210, 6'b0, cset_ad7794});
			regmap_pkg::addr_capture_status: rd_mux = regmap_pkg::lb_data_t'(cap_status);
			regmap_pkg::addr_freq_a:       rd_mux = regmap_pkg::lb_data_t'(freq_a);
			regmap_pkg::addr_freq_b:       rd_mux = regmap_pkg::lb_data_t'(freq_b);
			default: ;
		endcase
	end

	// two-stage read pipe, same latency for registers and memory
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			rd_reg_q <= '0;
			rd_mem_q <= 1'b0;
			lb_din   <= '0;
		end else begin
			rd_reg_q <= rd_stb ? rd_mux : '0;
			rd_mem_q <= rd_stb && in_capture;
			lb_din   <= rd_mem_q ? regmap_pkg::lb_data_t'(cap_rd_data) : rd_reg_q;
		end
	end

endmodule

/* design/idelay_loader.sv */
`timescale 1ns/10ps

module idelay_loader (
	input  logic                    lb_clk,
	input  logic                    reset,
	input  regmap_pkg::idelay_cmd_t idelay_cmd,
	output logic [15:0]             idelay_ld,
	output logic [4:0]              idelay_value
);

	logic [1:0]                       stb_sr;    // strobe history
	logic [regmap_pkg::idelay_aw-1:0] tap_addr;  // latched tap number

	// hold address and value from the write on
	always_ff @(posedge lb_clk) begin
		if (idelay_cmd.strobe) begin
			tap_addr     <= idelay_cmd.addr;
			idelay_value <= idelay_cmd.value;
		end
	end

	// two-deep history stretches the load to two cycles
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			stb_sr <= '0;
		end else begin
			stb_sr <= {stb_sr[0], idelay_cmd.strobe};
		end
	end

	// tap n drives load bit 15-n, U3 taps in the low half of the address range
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			idelay_ld <= '0;
		end else begin
			for (int i = 0; i < 16; i++)
				idelay_ld[i] <= (|stb_sr) && (tap_addr == 4'(15 - i));
		end
	end

endmodule

/* design/freq_count.sv */
`timescale 1ns/10ps

module freq_count (
	input  logic              lb_clk,
	input  logic              reset,
	input  logic              f_in,       // measured clock, asynchronous
	output regmap_pkg::freq_t frequency   // edges per gate
);

	localparam int gw = regmap_pkg::freq_gate_log2;

	logic [2:0]        f_sr;    // two sync stages plus one for edge detect
	logic              rise;
	logic [gw-1:0]     gate;    // gate window counter
	logic              gate_end;
	regmap_pkg::freq_t accum;

	assign rise     = f_sr[1] & ~f_sr[2];
	assign gate_end = &gate;

	always_ff @(posedge lb_clk) begin
		if (reset) begin
			f_sr <= '0;
		end else begin
			f_sr <= {f_sr[1:0], f_in};
		end
	end

	// accumulate over the gate, publish and restart at the wrap
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			gate      <= '0;
			accum     <= '0;
			frequency <= '0;
		end else begin
			gate <= gate + 1'b1;
			if (gate_end) begin
				frequency <= accum + regmap_pkg::freq_t'(rise);  // last cycle counts too
				accum     <= '0;
			end else begin
				accum <= accum + regmap_pkg::freq_t'(rise);
			end
		end
	end

endmodule

/* design/sync_generate.sv */
`timescale 1ns/10ps

module sync_generate #(
	parameter int cw   = 10,   // cset width
	parameter int minc = 256   // shortest allowed period
) (
	input  logic          lb_clk,
	input  logic          reset,
	input  logic [cw-1:0] cset,
	output logic          sync
);

	logic [cw-1:0] period;  // clamped
	logic [cw-1:0] half;
	logic [cw-1:0] cnt;     // counts down to zero

	assign period = (cset < cw'(minc)) ? cw'(minc) : cset;
	assign half   = period >> 1;

	always_ff @(posedge lb_clk) begin
		if (reset) begin
			cnt  <= '0;
			sync <= 1'b0;
		end else begin
			if (cnt == '0)
				cnt <= period - 1'b1;  // wrap, restart
			else
				cnt <= cnt - 1'b1;
			sync <= cnt >= half;  // upper half of count = first half of period
		end
	end

endmodule

/* design/capture_mem.sv */
`timescale 1ns/10ps

module capture_mem (
	input  logic                      lb_clk,
	input  logic                      reset,
	input  regmap_pkg::capture_ctrl_t capture_ctrl,
	input  adc_pkg::adc_bus_t         adc_data,
	input  logic                      adc_valid,
	input  adc_pkg::capture_addr_t    rd_addr,   // {chan, index}
	output adc_pkg::sample_t          rd_data,
	output adc_pkg::capture_status_t  status
);

	localparam int aw = adc_pkg::capture_aw;

	logic                  run;
	logic                  full;
	adc_pkg::capture_ptr_t ptr;
	logic                  wr_en;
	logic                  last;  // this write fills the last slot

	adc_pkg::sample_t mem [adc_pkg::n_chan][adc_pkg::capture_depth];

	assign wr_en = run & adc_valid;
	assign last  = &ptr[aw-1:0];

	// one-shot fill control
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			run  <= 1'b0;
			full <= 1'b0;
			ptr  <= '0;
		end else if (capture_ctrl.trig) begin
			run  <= 1'b1;
			full <= 1'b0;
			ptr  <= '0;
		end else if (wr_en) begin
			ptr <= ptr + 1'b1;  // reaches depth on the last write
			if (last) begin
				run  <= 1'b0;
				full <= 1'b1;
			end
		end
	end

	// masked per-channel writes, channels masked off keep old data
	always_ff @(posedge lb_clk) begin
		for (int ch = 0; ch < adc_pkg::n_chan; ch++) begin
			if (wr_en && capture_ctrl.mask[ch])
				mem[ch][ptr[aw-1:0]] <= adc_data[ch];
		end
	end

	// registered readout
	always_ff @(posedge lb_clk) begin
		rd_data <= mem[rd_addr[aw +: adc_pkg::chan_aw]][rd_addr[aw-1:0]];
	end

	assign status.run     = run;
	assign status.full    = full;
	assign status.pointer = ptr;

endmodule

/* design/digitizer_config.sv */
`timescale 1ns/10ps

module digitizer_config (
	input  logic                 lb_clk,
	input  logic                 reset,
	input  logic                 lb_strobe,
	input  logic                 lb_rd,
	input  regmap_pkg::lb_addr_t lb_addr,
	input  regmap_pkg::lb_data_t lb_dout,
	input  logic                 mmcm_locked,
	input  adc_pkg::adc_bus_t    adc_data,   // already on lb_clk
	input  logic                 adc_valid,
	input  logic                 meas_clk_a,
	input  logic                 meas_clk_b,
	output regmap_pkg::lb_data_t lb_din,
	output logic                 pwr_en,
	output logic                 adc_pdwn,
	output logic [7:0]           bitslip_u2,
	output logic [7:0]           bitslip_u3,
	output logic [7:0]           idelay_ld_u2,
	output logic [7:0]           idelay_ld_u3,
	output logic [4:0]           idelay_value,
	output logic                 sync_ad7794,
	output logic                 sync_tps62210
);

	regmap_pkg::periph_cfg_t     periph_cfg;
	regmap_pkg::idelay_cmd_t     idelay_cmd;
	regmap_pkg::capture_ctrl_t   capture_ctrl;
	logic [regmap_pkg::cset_ad7794_w-1:0]   cset_ad7794;
	logic [regmap_pkg::cset_tps62210_w-1:0] cset_tps62210;
	adc_pkg::capture_addr_t      cap_rd_addr;
	adc_pkg::sample_t            cap_rd_data;
	adc_pkg::capture_status_t    cap_status;
	regmap_pkg::freq_t           freq_a, freq_b;
	logic [15:0]                 idelay_ld;

	assign pwr_en       = periph_cfg.pwr_en;
	assign adc_pdwn     = periph_cfg.adc_pdwn;  // both ADCs share one pin
	assign bitslip_u2   = periph_cfg.bitslip_u2;
	assign bitslip_u3   = periph_cfg.bitslip_u3;
	assign idelay_ld_u2 = idelay_ld[7:0];
	assign idelay_ld_u3 = idelay_ld[15:8];

	config_regs u_config_regs (
		.lb_clk, .reset, .lb_strobe, .lb_rd, .lb_addr, .lb_dout, .mmcm_locked,
		.lb_din, .periph_cfg, .idelay_cmd, .capture_ctrl,
		.cset_ad7794, .cset_tps62210,
		.cap_rd_addr, .cap_rd_data, .cap_status, .freq_a, .freq_b
	);

	idelay_loader u_idelay_loader (.lb_clk, .reset, .idelay_cmd, .idelay_ld, .idelay_value);

	capture_mem u_capture_mem (
		.lb_clk, .reset, .capture_ctrl, .adc_data, .adc_valid,
		.rd_addr(cap_rd_addr), .rd_data(cap_rd_data), .status(cap_status)
	);

	freq_count u_freq_a (.lb_clk, .reset, .f_in(meas_clk_a), .frequency(freq_a));
	freq_count u_freq_b (.lb_clk, .reset, .f_in(meas_clk_b), .frequency(freq_b));

	sync_generate #(
		.cw(regmap_pkg::cset_ad7794_w), .minc(regmap_pkg::sync_ad7794_minc)
	) u_sync_ad7794 (.lb_clk, .reset, .cset(cset_ad7794), .sync(sync_ad7794));

	sync_generate #(
		.cw(regmap_pkg::cset_tps62210_w), .minc(regmap_pkg::sync_tps62210_minc)
	) u_sync_tps62210 (.lb_clk, .reset, .cset(cset_tps62210), .sync(sync_tps62210));

endmodule

/* verif/digitizer_config_tb.sv */
`timescale 1ns/10ps

module digitizer_config_tb;

	localparam int clk_period = 20;
	localparam int drive_dly  = 1;   // inputs change this long after the rising edge
	localparam int half_a     = 4;   // meas_clk_a half period in lb_clk cycles
	localparam int half_b     = 16;
	localparam int gate_cycles = 1 << regmap_pkg::freq_gate_log2;
	localparam int fill_limit = 4096;  // cycles allowed for 256 random-valid samples
	// worst-case test lengths in lb_clk cycles
	localparam int len_regs    = 80;
	localparam int len_clk     = 80;
	localparam int len_idelay  = 100;
	localparam int len_sync    = 3 * 2 * 4 * 512;              // three settings times two generators
	localparam int len_capture = 2 * (fill_limit + 3 * 2048 + 40);
	localparam int len_freq    = 3 * gate_cycles + 40;
	localparam int len_total   = 16 + len_regs + len_clk + len_idelay + len_sync + len_capture
		+ len_freq;
	localparam int watchdog_cycles = len_total + len_total / 2;

	logic                 lb_clk, reset, lb_strobe, lb_rd, mmcm_locked;
	regmap_pkg::lb_addr_t lb_addr;
	regmap_pkg::lb_data_t lb_dout, lb_din;
	adc_pkg::adc_bus_t    adc_data;
	logic                 adc_valid, meas_clk_a, meas_clk_b;
	logic                 pwr_en, adc_pdwn, sync_ad7794, sync_tps62210;
	logic [7:0]           bitslip_u2, bitslip_u3, idelay_ld_u2, idelay_ld_u3;
	logic [4:0]           idelay_value;

	integer seed;
	int     errors = 0;
	int     test_start, tests_run, tests_failed;
	int     cyc = 0;  // lb_clk cycles since time zero

	digitizer_config u_digitizer_config (.*);

	initial begin
		lb_clk = 1'b0;
		forever #(clk_period / 2) lb_clk = ~lb_clk;
	end

	always @(posedge lb_clk) cyc <= cyc + 1;

	// measured clocks give 512 and 128 rising edges per gate
	initial begin
		meas_clk_a = 1'b0;
		forever begin
			repeat (half_a) @(posedge lb_clk);
			#(drive_dly) meas_clk_a = ~meas_clk_a;
		end
	end

	initial begin
		meas_clk_b = 1'b0;
		forever begin
			repeat (half_b) @(posedge lb_clk);
			#(drive_dly) meas_clk_b = ~meas_clk_b;
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic check_near(input string name, input int expected, input int actual,
		input int tol);
		assert ((actual >= expected - tol) && (actual <= expected + tol)) else begin
			$display("mismatch at %0t ns: %s expected %0d +/- %0d, got %0d", $time, name,
				expected, tol, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors - test_start;
		tests_run++;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d bad checks", name, n);
		end
		test_start = errors;
	endtask

	// one-cycle strobe and the write lands on the next edge
	task automatic bus_write(input regmap_pkg::lb_addr_t addr, input regmap_pkg::lb_data_t data);
		@(posedge lb_clk);
		#(drive_dly);
		lb_strobe = 1'b1;
		lb_rd     = 1'b0;
		lb_addr   = addr;
		lb_dout   = data;
		@(posedge lb_clk);  // write edge
		#(drive_dly);
		lb_strobe = 1'b0;
	endtask

	task automatic bus_read(input regmap_pkg::lb_addr_t addr, output regmap_pkg::lb_data_t data);
		@(posedge lb_clk);
		#(drive_dly);
		lb_strobe = 1'b1;
		lb_rd     = 1'b1;
		lb_addr   = addr;
		@(posedge lb_clk);  // strobe edge
		#(drive_dly);
		lb_strobe = 1'b0;
		lb_rd     = 1'b0;
		@(posedge lb_clk);
		#(drive_dly) data = lb_din;  // settled since this edge
	endtask

	task automatic check_read(input regmap_pkg::lb_addr_t addr,
		input regmap_pkg::lb_data_t expected, input string name);
		regmap_pkg::lb_data_t data;
		bus_read(addr, data);
		check_value(name, expected, data);
	endtask

	function automatic int expected_period(input int cset, input int minc);
		return (cset > minc) ? cset : minc;
	endfunction

	function automatic adc_pkg::sample_t sample_pattern(input int ch, input int idx,
		input logic [15:0] key);
		return adc_pkg::sample_t'(ch * 4096 + idx) ^ key;
	endfunction

	// {run, full, pointer[8:0]} as it reads back
	function automatic regmap_pkg::lb_data_t status_word(input logic run, input logic full,
		input int ptr);
		return 32'({run, full, 9'(ptr)});
	endfunction

	task automatic config_regs_rw();
		check_read(regmap_pkg::addr_banyan_mask, 32'hff, "banyan mask after reset");
		bus_write(regmap_pkg::addr_periph_config, 32'h3);
		check_value("pwr_en", 1, pwr_en);
		check_value("adc_pdwn", 1, adc_pdwn);
		bus_write(regmap_pkg::addr_periph_config, 32'h1);
		check_value("pwr_en", 1, pwr_en);
		check_value("adc_pdwn", 0, adc_pdwn);
		bus_write(regmap_pkg::addr_periph_config, 32'h2);
		check_value("pwr_en", 0, pwr_en);
		check_value("adc_pdwn", 1, adc_pdwn);
		bus_write(regmap_pkg::addr_bitslip, 32'h0000_a55c);
		check_value("bitslip_u2", 32'h5c, bitslip_u2);
		check_value("bitslip_u3", 32'ha5, bitslip_u3);
		check_read(regmap_pkg::addr_periph_config, 32'h2, "periph config readback");
		check_read(regmap_pkg::addr_bitslip, 32'ha55c, "bitslip readback");
		check_read(24'd7, 32'h0, "unmapped word 7");        // hole in the map
		check_read(24'h000200, 32'h0, "unmapped word 0x200");
		end_test("config registers");
	endtask

	task automatic clock_status_seq();
		check_read(regmap_pkg::addr_clk_status, 32'(regmap_pkg::clk_reset), "clk status");
		bus_write(regmap_pkg::addr_clk_status, 32'h2);  // verify too early
		check_read(regmap_pkg::addr_clk_status, 32'(regmap_pkg::clk_reset), "clk status");
		bus_write(regmap_pkg::addr_clk_status, 32'h1);
		check_read(regmap_pkg::addr_clk_status, 32'(regmap_pkg::clk_set_up), "clk status");
		bus_write(regmap_pkg::addr_clk_status, 32'h2);
		check_read(regmap_pkg::addr_clk_status, 32'(regmap_pkg::clk_verified), "clk status");
		@(posedge lb_clk);
		#(drive_dly) mmcm_locked = 1'b0;  // one-cycle lock loss
		@(posedge lb_clk);
		#(drive_dly) mmcm_locked = 1'b1;
		check_read(regmap_pkg::addr_clk_status, 32'(regmap_pkg::clk_reset), "clk status");
		end_test("clock status");
	endtask

	// load bit 15-tap high on the 2nd and 3rd edge after the write edge
	task automatic idelay_load(input int tap, input logic [4:0] value);
		logic [15:0] exp_ld;
		bus_write(regmap_pkg::idelay_base + 24'(tap), 32'(value));
		for (int k = 1; k <= 4; k++) begin
			@(posedge lb_clk);
			#(drive_dly);
			exp_ld = (k == 2 || k == 3) ? (16'h1 << (15 - tap)) : 16'h0;
			check_value("{idelay_ld_u3, idelay_ld_u2}", 32'(exp_ld),
				32'({idelay_ld_u3, idelay_ld_u2}));
			check_value("idelay_value", 32'(value), 32'(idelay_value));
		end
	endtask

	task automatic idelay_strobes();
		idelay_load(0, 5'd3);
		idelay_load(5, 5'd17);
		idelay_load(9, 5'd30);
		idelay_load(15, 5'd8);
		end_test("idelay load");
	endtask

	// cycles between the 2nd and 3rd rising edge since the first may follow an old period
	task automatic measure_period(input bit sel_tps, output int cycles);
		logic prev, cur;
		int   edges, count, guard;
		prev   = sel_tps ? sync_tps62210 : sync_ad7794;
		edges  = 0;
		count  = 0;
		guard  = 0;
		cycles = -1;
		while (edges < 3 && guard < 4 * 1024) begin
			@(posedge lb_clk);
			#(drive_dly) cur = sel_tps ? sync_tps62210 : sync_ad7794;
			count++;
			guard++;
			if (cur && !prev) begin
				edges++;
				if (edges == 3)
					cycles = count;
				count = 0;
			end
			prev = cur;
		end
		if (cycles < 0)
			report_failure(sel_tps ? "sync_tps62210 stopped toggling" :
				"sync_ad7794 stopped toggling");
	endtask

	task automatic sync_periods();
		int ad_set [3] = '{0, 100, 400};
		int tps_set [3] = '{0, 20, 50};
		int period;
		for (int i = 0; i < 3; i++) begin
			if (i > 0) begin  // first pass runs on the reset csets
				bus_write(regmap_pkg::addr_sync_cset, 32'((tps_set[i] << 16) | ad_set[i]));
				check_read(regmap_pkg::addr_sync_cset, 32'((tps_set[i] << 16) | ad_set[i]),
					"sync cset readback");
			end
			measure_period(1'b0, period);
			check_value("sync_ad7794 period", expected_period(ad_set[i], 256), period);
			measure_period(1'b1, period);
			check_value("sync_tps62210 period", expected_period(tps_set[i], 32), period);
		end
		end_test("sync generators");
	endtask

	task automatic capture_fill(input logic [15:0] key);
		int idx, guard, rnd;
		bus_write(regmap_pkg::addr_capture_trig, 32'h1);
		check_read(regmap_pkg::addr_capture_status, status_word(1'b1, 1'b0, 0), "capture status");
		idx   = 0;
		guard = 0;
		while (idx < 256 && guard < fill_limit) begin
			@(posedge lb_clk);
			#(drive_dly);
			rnd       = $random(seed);
			adc_valid = rnd[0];
			for (int ch = 0; ch < 8; ch++)
				adc_data[ch] = sample_pattern(ch, idx, key);
			if (adc_valid)
				idx++;
			guard++;
		end
		@(posedge lb_clk);
		#(drive_dly) adc_valid = 1'b0;
		if (idx < 256)
			report_failure("ADC sample driver ran out of cycles before 256 samples");
		check_read(regmap_pkg::addr_capture_status, status_word(1'b0, 1'b1, 256),
			"capture status");
	endtask

	// channels with mask set hold key_new data and the rest key_old
	task automatic capture_readback(input logic [7:0] mask, input logic [15:0] key_new,
		input logic [15:0] key_old);
		regmap_pkg::lb_data_t data;
		adc_pkg::sample_t     exp;
		for (int ch = 0; ch < 8; ch++) begin
			for (int idx = 0; idx < 256; idx++) begin
				bus_read(regmap_pkg::capture_base + 24'(ch * 256 + idx), data);
				exp = sample_pattern(ch, idx, mask[ch] ? key_new : key_old);
				check_value($sformatf("lb_din (capture ch%0d idx %0d)", ch, idx), 32'(exp), data);
			end
		end
	endtask

	task automatic capture_cycle();
		capture_fill(16'h5a5a);
		capture_readback(8'hff, 16'h5a5a, 16'h5a5a);
		bus_write(regmap_pkg::addr_banyan_mask, 32'h0f);  // low four channels only
		capture_fill(16'ha3c1);
		capture_readback(8'h0f, 16'ha3c1, 16'h5a5a);
		end_test("capture memory");
	endtask

	task automatic freq_readout();
		regmap_pkg::lb_data_t data;
		while (cyc < 16 + 3 * gate_cycles)  // two full gates after reset
			@(posedge lb_clk);
		bus_read(regmap_pkg::addr_freq_a, data);
		check_near("freq_a", gate_cycles / (2 * half_a), int'(data), 1);
		bus_read(regmap_pkg::addr_freq_b, data);
		check_near("freq_b", gate_cycles / (2 * half_b), int'(data), 1);
		end_test("frequency counters");
	endtask

	initial begin
		reset        = 1'b1;
		lb_strobe    = 1'b0;
		lb_rd        = 1'b0;
		lb_addr      = '0;
		lb_dout      = '0;
		mmcm_locked  = 1'b1;
		adc_valid    = 1'b0;
		adc_data     = '0;
		seed         = 32'h02afbd75;
		test_start   = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (16) @(posedge lb_clk);
		#(drive_dly) reset = 1'b0;
		config_regs_rw();
		clock_status_seq();
		idelay_strobes();
		sync_periods();
		capture_cycle();
		freq_readout();
		$display("%0d tests run, %0d failed, %0d bad checks", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* tb.f */
design/regmap_pkg.sv
design/adc_pkg.sv
design/config_regs.sv
design/idelay_loader.sv
design/freq_count.sv
design/sync_generate.sv
design/capture_mem.sv
design/digitizer_config.sv
verif/digitizer_config_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the digitizer_config testbench with Verilator.
# Exit status is zero only when the pass message shows up in sim.log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module digitizer_config_tb \
	-f tb.f \
	-Mdir obj_dir -o sim_digitizer_config \
	&& ./obj_dir/sim_digitizer_config 2>&1 | tee sim.log \
	&& grep -qx "All tests passed!" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
